//--- phaethon.f
phaethonPkg.sv
cpuSequencer.sv
instrDecode.sv
regFile.sv
memAccess.sv
execUnit.sv
phaethonCore.sv
phaethonCore_chk.sv
phaethonCoreTb.sv

//--- Bender.yml
package:
  name: phaethon

sources:
  - phaethonPkg.sv
  - cpuSequencer.sv
  - instrDecode.sv
  - regFile.sv
  - memAccess.sv
  - execUnit.sv
  - phaethonCore.sv
  - target: simulation
    files:
      - phaethonCore_chk.sv
      - phaethonCoreTb.sv

//--- phaethonCoreTb.sv
`timescale 1ns/100ps

module phaethonCoreTb;

  logic                clk;
  logic                reset;
  phaethonPkg::wordT   ramIn;
  phaethonPkg::wordT   ramAddress;
  phaethonPkg::wordT   ramOut;
  logic                readReq;
  logic                writeReq;
  phaethonPkg::wordT   ipointer;
  phaethonPkg::opcodeT opCode;
  phaethonPkg::wordT   debugOut;
  logic                debugValid;

  phaethonPkg::wordT ram  [1024];  // Memory seen by the DUT
  phaethonPkg::wordT prog [1024];  // Program image of the current test
  phaethonPkg::wordT mMem [1024];  // Reference model memory
  phaethonPkg::wordT mReg [64];
  phaethonPkg::wordT expQ [$];     // Expected debug values in order
  phaethonPkg::wordT haltIp;
  phaethonPkg::wordT pc;           // Emit address while building
  integer seed = 32'h3930;
  int gotCount = 0;
  int testErrors = 0;
  int totalErrors = 0;
  int testsFailed = 0;
  int testCount = 0;
  int checkCount = 0;
  time deadline = 400;

  phaethonCore phaethonCore_i (.*);

  bind phaethonCore phaethonCore_chk phaethonCoreChk_i (
    .clk, .reset, .readReq, .writeReq, .debugValid
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Memory model, fixed two-edge read latency
  always @(posedge clk) begin
    if (writeReq) ram[ramAddress[11:2]] <= ramOut;
    if (readReq) ramIn <= #1 ram[ramAddress[11:2]];
  end

  // Debug port against expected sequence
  always @(posedge clk) begin
    if (!reset && debugValid) begin
      checkCount++;
      assert (gotCount < expQ.size()) else begin
        $display("Extra debug output %h at %0t after the last expected value", debugOut, $time);
        testErrors++;
      end
      if (gotCount < expQ.size()) begin
        assert (debugOut == expQ[gotCount]) else begin
          $display("Mismatch at %0t: debug value %0d is %h, expected %h",
                   $time, gotCount, debugOut, expQ[gotCount]);
          testErrors++;
        end
      end
      gotCount++;
    end
  end

  // Ends the run when a test overruns its cycle budget
  initial begin
    while ($time <= deadline) @(posedge clk);
    $display("Timeout at %0t: the DUT did not reach its Stall in time", $time);
    $display("*** TEST FAILED ***");
    $finish;
  end

  function automatic int rnd(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic phaethonPkg::wordT encode(logic [7:0] op, int ra, int rb, int rc);
    return {2'b00, rc[5:0], 2'b00, rb[5:0], 2'b00, ra[5:0], op};
  endfunction

  // Forms named ...C carry a constant word
  function automatic logic hasConstWord(logic [7:0] op);
    case (op)
      phaethonPkg::MovRC, phaethonPkg::MovRdC, phaethonPkg::MovRdRo, phaethonPkg::MovdCR,
      phaethonPkg::MovdRoR, phaethonPkg::CmpRC, phaethonPkg::JmpC, phaethonPkg::JeC,
      phaethonPkg::JneC, phaethonPkg::JzRC, phaethonPkg::JnzRC, phaethonPkg::AddRRC,
      phaethonPkg::SubRRC: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic phaethonPkg::wordT modelLoad(phaethonPkg::wordT addr);
    return mMem[addr[11:2]];
  endfunction

  task automatic modelStore(phaethonPkg::wordT addr, phaethonPkg::wordT data);
    mMem[addr[11:2]] = data;
  endtask

  task automatic emit(phaethonPkg::wordT w);
    prog[pc[11:2]] = w;
    pc += 32'd4;
  endtask

  task automatic emitOp(logic [7:0] op, int ra, int rb, int rc);
    emit(encode(op, ra, rb, rc));
  endtask

  task automatic emitConst(logic [7:0] op, int ra, int rb, int rc, phaethonPkg::wordT k);
    emit(encode(op, ra, rb, rc));
    emit(k);
  endtask

  task automatic clearProg();
    for (int i = 0; i < 1024; i++) begin
      prog[i] = 32'h5eed0000 ^ (i * 32'h00010003);  // Distinct per word
    end
    pc = '0;
  endtask

  // ISA level run of prog, fills expQ, mMem and haltIp
  task automatic runModel(output int steps);
    phaethonPkg::wordT ip, next, w, k, a, b, c, sp, rhs;
    logic [7:0] op;
    logic [5:0] ra;
    logic halted;
    for (int i = 0; i < 1024; i++) mMem[i] = prog[i];
    for (int i = 0; i < 64; i++) mReg[i] = '0;
    expQ.delete();
    ip = '0;
    steps = 0;
    halted = 1'b0;
    while (!halted && steps < 4000) begin
      w    = mMem[ip[11:2]];
      next = ip + 32'd4;
      k    = mMem[next[11:2]];  // Constant word, if any
      op   = w[7:0];
      ra   = w[13:8];
      a    = mReg[w[13:8]];
      b    = mReg[w[21:16]];
      c    = mReg[w[29:24]];
      sp   = mReg[0];
      rhs  = (op == phaethonPkg::CmpRC) ? k : b;
      if (hasConstWord(op)) next = ip + 32'd8;
      steps++;
      case (op)
        phaethonPkg::MovRC:   mReg[ra] = k;
        phaethonPkg::MovRR:   mReg[ra] = b;
        phaethonPkg::MovRdC:  mReg[ra] = modelLoad(k);
        phaethonPkg::MovRdRo: mReg[ra] = modelLoad(k + b);
        phaethonPkg::MovRdR:  mReg[ra] = modelLoad(b);
        phaethonPkg::MovdCR:  modelStore(k, b);
        phaethonPkg::MovdRoR: modelStore(k + a, b);
        phaethonPkg::PushR: begin
          modelStore(sp, a);
          mReg[0] = sp + 32'd4;
        end
        phaethonPkg::PopR: begin
          mReg[ra] = modelLoad(sp - 32'd4);
          mReg[0]  = sp - 32'd4;  // Stack pointer write lands last
        end
        phaethonPkg::CallR: begin
          modelStore(sp, ip);
          mReg[0] = sp + 32'd4;
          next    = a;
        end
        phaethonPkg::Ret: begin
          next    = modelLoad(sp - 32'd4) + 32'd4;
          mReg[0] = sp - 32'd4;
        end
        phaethonPkg::CmpRR, phaethonPkg::CmpRC: begin
          mReg[1][phaethonPkg::flagEq] = (a == rhs);  // Unsigned compare
          mReg[1][phaethonPkg::flagLt] = (a < rhs);
          mReg[1][phaethonPkg::flagGt] = (a > rhs);
        end
        phaethonPkg::CmpERRR:  mReg[ra] = (b == c);
        phaethonPkg::CmpLtRRR: mReg[ra] = (b < c);
        phaethonPkg::JmpC:  next = k;
        phaethonPkg::JeC:   if (mReg[1][phaethonPkg::flagEq]) next = k;
        phaethonPkg::JneC:  if (!mReg[1][phaethonPkg::flagEq]) next = k;
        phaethonPkg::JzRC:  if (c == '0) next = k;
        phaethonPkg::JnzRC: if (c != '0) next = k;
        phaethonPkg::AddRRC: mReg[ra] = b + k;
        phaethonPkg::AddRRR: mReg[ra] = b + c;
        phaethonPkg::SubRRC: mReg[ra] = b - k;
        phaethonPkg::SubRRR: mReg[ra] = b - c;
        phaethonPkg::IncR:   mReg[ra] = a + 32'd1;
        phaethonPkg::DecR:   mReg[ra] = a - 32'd1;
        phaethonPkg::ShlRRR: mReg[ra] = b << c;  // Whole c as amount
        phaethonPkg::ShrRRR: mReg[ra] = b >> c;
        phaethonPkg::NegRR:  mReg[ra] = 32'd0 - b;
        phaethonPkg::DoutR:  expQ.push_back(a);
        phaethonPkg::Stall: begin
          haltIp = ip;
          halted = 1'b1;
        end
        default: begin
        end
      endcase
      ip = next;
    end
  endtask

  task automatic runTest(string name);
    int steps;
    @(posedge clk);
    #1 reset = 1'b1;
    runModel(steps);
    deadline = $time + (10 * steps + 60) * 4;  // At most 10 cycles per instruction
    foreach (ram[i]) ram[i] = prog[i];
    gotCount   = 0;
    testErrors = 0;
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;
    while (opCode != phaethonPkg::Stall) @(posedge clk);
    repeat (15) @(posedge clk);  // Three trips round the 5-cycle stall loop
    assert (ipointer == haltIp) else begin
      $display("Mismatch at %0t: ipointer %h, expected halt at %h", $time, ipointer, haltIp);
      testErrors++;
    end
    assert (gotCount == expQ.size()) else begin
      $display("Missing debug output: %0d of %0d values seen", gotCount, expQ.size());
      testErrors++;
    end
    foreach (ram[i]) begin
      assert (ram[i] == mMem[i]) else begin
        $display("Mismatch at %0t: ram[%0d] is %h, expected %h", $time, i, ram[i], mMem[i]);
        testErrors++;
      end
    end
    checkCount  += 2 + 1024;
    testCount++;
    totalErrors += testErrors;
    if (testErrors != 0) testsFailed++;
    $display("%-7s %s  %0d debug values, %0d errors", name,
             (testErrors == 0) ? "pass" : "fail", gotCount, testErrors);
  endtask

  task automatic arithTest();
    phaethonPkg::opcodeT aluOps [10] = '{
      phaethonPkg::AddRRC, phaethonPkg::AddRRR, phaethonPkg::SubRRC, phaethonPkg::SubRRR,
      phaethonPkg::IncR, phaethonPkg::DecR, phaethonPkg::ShlRRR, phaethonPkg::ShrRRR,
      phaethonPkg::NegRR, phaethonPkg::MovRR
    };
    phaethonPkg::opcodeT op;
    int ra, rb, rc;
    logic isShift;
    clearProg();
    repeat (16) begin
      op = aluOps[rnd(10)];
      ra = 2 + rnd(62);  // r0 and r1 stay sp and flags
      rb = 2 + rnd(62);
      rc = 2 + rnd(62);
      isShift = (op == phaethonPkg::ShlRRR) || (op == phaethonPkg::ShrRRR);
      emitConst(phaethonPkg::MovRC, rb, 0, 0, $random(seed));
      emitConst(phaethonPkg::MovRC, rc, 0, 0, isShift ? rnd(40) : $random(seed));  // Some past 31
      if (op == phaethonPkg::AddRRC || op == phaethonPkg::SubRRC)
        emitConst(op, ra, rb, 0, $random(seed));
      else
        emitOp(op, ra, rb, rc);
      emitOp(phaethonPkg::DoutR, ra, 0, 0);
    end
    emitOp(phaethonPkg::Stall, 0, 0, 0);
    runTest("arith");
  endtask

  task automatic memTest();
    phaethonPkg::wordT base;
    int dr, ar, lr;
    clearProg();
    for (int k = 0; k < 4; k++) begin
      base = 32'd2048 + 128 * k;
      dr = 2 + rnd(30);   // Data
      ar = 32 + rnd(32);  // Address or offset, kept apart from data
      lr = 2 + rnd(30);
      emitConst(phaethonPkg::MovRC, dr, 0, 0, $random(seed));
      emitConst(phaethonPkg::MovdCR, 0, dr, 0, base);
      emitConst(phaethonPkg::MovRC, ar, 0, 0, 4 * (1 + rnd(8)));
      emitConst(phaethonPkg::MovRC, dr, 0, 0, $random(seed));
      emitConst(phaethonPkg::MovdRoR, ar, dr, 0, base);
      emitOp(phaethonPkg::MovRR, lr, dr, 0);
      emitOp(phaethonPkg::DoutR, lr, 0, 0);
      emitConst(phaethonPkg::MovRdC, lr, 0, 0, base);
      emitOp(phaethonPkg::DoutR, lr, 0, 0);
      emitConst(phaethonPkg::MovRdRo, lr, ar, 0, base);
      emitOp(phaethonPkg::DoutR, lr, 0, 0);
      emitConst(phaethonPkg::MovRC, ar, 0, 0, base + 4 * rnd(16));  // May hit fill words
      emitOp(phaethonPkg::MovRdR, lr, ar, 0);
      emitOp(phaethonPkg::DoutR, lr, 0, 0);
    end
    emitOp(phaethonPkg::Stall, 0, 0, 0);
    runTest("memory");
  endtask

  task automatic flowTest();
    phaethonPkg::wordT vx, vy;
    int x, y, d, kind;
    logic sel;
    clearProg();
    repeat (8) begin
      x  = 2 + rnd(30);
      y  = 32 + rnd(16);
      d  = 48 + rnd(12);
      vx = rnd(4);
      vy = rnd(2) ? vx : rnd(4);  // Equal operands often
      emitConst(phaethonPkg::MovRC, x, 0, 0, vx);
      emitConst(phaethonPkg::MovRC, y, 0, 0, vy);
      emitConst(phaethonPkg::MovRC, 60, 0, 0, 32'hc0de0000 + pc);  // Marker value
      kind = rnd(4);
      sel  = rnd(2);
      case (kind)
        0: emitOp(phaethonPkg::CmpRR, x, y, 0);
        1: emitConst(phaethonPkg::CmpRC, x, 0, 0, vy);
        2: emitOp(phaethonPkg::CmpERRR, d, x, y);
        default: emitOp(phaethonPkg::CmpLtRRR, d, x, y);
      endcase
      emitOp(phaethonPkg::DoutR, 1, 0, 0);  // All three flag bits
      // Jump over the marker DoutR
      if (kind < 2)
        emitConst(sel ? phaethonPkg::JeC : phaethonPkg::JneC, 0, 0, 0, pc + 12);
      else
        emitConst(sel ? phaethonPkg::JzRC : phaethonPkg::JnzRC, 0, 0, d, pc + 12);
      emitOp(phaethonPkg::DoutR, 60, 0, 0);
      emitOp(phaethonPkg::DoutR, x, 0, 0);
    end
    emitOp(phaethonPkg::Stall, 0, 0, 0);
    runTest("flow");
  endtask

  task automatic stackTest();
    int r;
    clearProg();
    emitConst(phaethonPkg::MovRC, 0, 0, 0, 32'd3072 + 4 * rnd(16));  // Stack base
    repeat (4) begin
      r = 2 + rnd(60);
      emitConst(phaethonPkg::MovRC, r, 0, 0, $random(seed));
      emitOp(phaethonPkg::PushR, r, 0, 0);
    end
    repeat (3) begin  // One entry left behind
      r = 2 + rnd(60);
      emitOp(phaethonPkg::PopR, r, 0, 0);
      emitOp(phaethonPkg::DoutR, r, 0, 0);
    end
    emitConst(phaethonPkg::MovRC, 62, 0, 0, 32'd1024);
    emitOp(phaethonPkg::CallR, 62, 0, 0);
    emitOp(phaethonPkg::DoutR, 0, 0, 0);
    emitOp(phaethonPkg::Stall, 0, 0, 0);
    pc = 32'd1024;  // Subroutine
    emitOp(phaethonPkg::DoutR, 0, 0, 0);
    emitOp(phaethonPkg::PushR, 63, 0, 0);
    emitOp(phaethonPkg::IncR, 63, 0, 0);
    emitOp(phaethonPkg::DoutR, 63, 0, 0);
    emitOp(phaethonPkg::PopR, 63, 0, 0);
    emitOp(phaethonPkg::DoutR, 63, 0, 0);
    emitOp(phaethonPkg::Ret, 0, 0, 0);
    runTest("stack");
  endtask

  task automatic haltTest();
    phaethonPkg::wordT stallAt;
    clearProg();
    stallAt = 32'd512 + 4 * rnd(64);
    emitConst(phaethonPkg::MovRC, 2, 0, 0, $random(seed));
    emitOp(phaethonPkg::DoutR, 2, 0, 0);
    emitConst(phaethonPkg::JmpC, 0, 0, 0, stallAt);
    emitOp(phaethonPkg::DoutR, 2, 0, 0);  // Skipped
    pc = stallAt;
    emitOp(phaethonPkg::Stall, 0, 0, 0);
    emitOp(phaethonPkg::DoutR, 2, 0, 0);  // Never reached
    runTest("halt");
  endtask

  initial begin
    reset = 1'b1;
    ramIn = '0;
    arithTest();
    memTest();
    flowTest();
    stackTest();
    haltTest();
    totalErrors += phaethonCore_i.phaethonCoreChk_i.failCount;
    $display("%0d tests, %0d failed, %0d checks, %0d errors (%0d from assertions)",
             testCount, testsFailed, checkCount, totalErrors,
             phaethonCore_i.phaethonCoreChk_i.failCount);
    if (totalErrors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- phaethonCore_chk.sv
`timescale 1ns/100ps

module phaethonCore_chk (
  input logic clk,
  input logic reset,
  input logic readReq,
  input logic writeReq,
  input logic debugValid
);

  int failCount = 0;  // Summed into the testbench totals

  // One direction per request
  reqExclusive: assert property (@(posedge clk) disable iff (reset) !(readReq && writeReq))
    else begin
      $error("readReq and writeReq high together");
      failCount++;
    end

  // Plain one-cycle pulses
  readPulse: assert property (@(posedge clk) disable iff (reset) readReq |=> !readReq)
    else begin
      $error("readReq held longer than one cycle");
      failCount++;
    end

  writePulse: assert property (@(posedge clk) disable iff (reset) writeReq |=> !writeReq)
    else begin
      $error("writeReq held longer than one cycle");
      failCount++;
    end

  // Fetch starts right after reset
  firstFetch: assert property (@(posedge clk) $fell(reset) |=> readReq)
    else begin
      $error("no instruction fetch in the first cycle after reset");
      failCount++;
    end

  debugPulse: assert property (@(posedge clk) disable iff (reset) debugValid |=> !debugValid)
    else begin
      $error("debugValid held longer than one cycle");
      failCount++;
    end

endmodule

//--- phaethonCore.sv
`timescale 1ns/100ps

module phaethonCore (
  input  logic                clk,
  input  logic                reset,
  input  phaethonPkg::wordT   ramIn,       // Word at requested address
  output phaethonPkg::wordT   ramAddress,
  output phaethonPkg::wordT   ramOut,      // Store data
  output logic                readReq,
  output logic                writeReq,
  output phaethonPkg::wordT   ipointer,
  output phaethonPkg::opcodeT opCode,      // Opcode of current instruction
  output phaethonPkg::wordT   debugOut,
  output logic                debugValid
);

  phaethonPkg::instrT     instr;
  phaethonPkg::operandT   operand;
  phaethonPkg::memReqT    memReq;
  phaethonPkg::writebackT wb;
  phaethonPkg::wordT      ip;
  phaethonPkg::wordT      dataWord;   // Constant word of 8-byte instructions
  phaethonPkg::wordT      ramValue;   // Data read result
  phaethonPkg::wordT      sp;
  phaethonPkg::flagsT     flags;
  logic is8;
  logic isRam;
  logic readsRam;
  logic decodeLoad;
  logic operandLoad;
  logic commit;

  assign ipointer = ip;
  assign opCode   = instr.op;

  // Mode FSM and memory port
  cpuSequencer cpuSequencer_i (
    .clk, .reset, .ramIn, .is8, .isRam, .readsRam, .memReq, .wb,
    .decodeLoad, .operandLoad, .commit, .ip, .dataWord, .ramValue,
    .ramAddress, .ramOut, .readReq, .writeReq
  );

  instrDecode instrDecode_i (
    .clk, .reset, .ramIn, .decodeLoad, .instr, .is8, .isRam, .readsRam
  );

  regFile regFile_i (
    .clk, .reset, .instr, .operandLoad, .commit, .wb, .operand, .sp, .flags
  );

  // Address and store data
  memAccess memAccess_i (
    .instr, .operand, .dataWord, .sp, .ip, .memReq
  );

  execUnit execUnit_i (
    .clk, .reset, .instr, .operand, .dataWord, .ramValue, .sp, .flags, .ip,
    .commit, .wb, .debugOut, .debugValid
  );

endmodule

//--- execUnit.sv
`timescale 1ns/100ps

module execUnit (
  input  logic                   clk,
  input  logic                   reset,
  input  phaethonPkg::instrT     instr,
  input  phaethonPkg::operandT   operand,
  input  phaethonPkg::wordT      dataWord,
  input  phaethonPkg::wordT      ramValue,
  input  phaethonPkg::wordT      sp,
  input  phaethonPkg::flagsT     flags,
  input  phaethonPkg::wordT      ip,
  input  logic                   commit,
  output phaethonPkg::writebackT wb,
  output phaethonPkg::wordT      debugOut,
  output logic                   debugValid
);

  phaethonPkg::wordT  cmpRhs;    // Right side of flag compares
  phaethonPkg::flagsT cmpFlags;
  logic               isDout;

  // Unsigned flag compare against register or constant
  always_comb begin
    cmpRhs   = (instr.op == phaethonPkg::CmpRC) ? dataWord : operand.b;
    cmpFlags = '0;
    cmpFlags[phaethonPkg::flagEq] = (operand.a == cmpRhs);
    cmpFlags[phaethonPkg::flagLt] = (operand.a < cmpRhs);
    cmpFlags[phaethonPkg::flagGt] = (operand.a > cmpRhs);
  end

  always_comb begin
    wb          = '0;
    wb.destReg  = instr.ra;  // First register field is the destination
    wb.flags    = cmpFlags;
    wb.ipTarget = dataWord;  // Jump constant by default
    case (instr.op)
      phaethonPkg::MovRC: {wb.destEn, wb.destData} = {1'b1, dataWord};
      phaethonPkg::MovRR: {wb.destEn, wb.destData} = {1'b1, operand.b};
      phaethonPkg::MovRdC, phaethonPkg::MovRdRo, phaethonPkg::MovRdR: begin
        wb.destEn   = 1'b1;
        wb.destData = ramValue;
      end
      phaethonPkg::PushR: {wb.spEn, wb.spData} = {1'b1, sp + phaethonPkg::wordBytes};
      phaethonPkg::PopR: begin
        wb.destEn   = 1'b1;
        wb.destData = ramValue;
        wb.spEn     = 1'b1;
        wb.spData   = sp - phaethonPkg::wordBytes;
      end
      phaethonPkg::CallR: begin
        wb.spEn     = 1'b1;
        wb.spData   = sp + phaethonPkg::wordBytes;
        wb.ipLoad   = 1'b1;
        wb.ipTarget = operand.a;
      end
      phaethonPkg::Ret: begin
        wb.spEn     = 1'b1;
        wb.spData   = sp - phaethonPkg::wordBytes;
        wb.ipLoad   = 1'b1;
        wb.ipTarget = ramValue + phaethonPkg::wordBytes;  // Past the CallR
      end
      phaethonPkg::CmpRR, phaethonPkg::CmpRC: wb.flagsEn = 1'b1;
      phaethonPkg::CmpERRR: begin
        wb.destEn   = 1'b1;
        wb.destData = phaethonPkg::wordT'(operand.b == operand.c);
      end
      phaethonPkg::CmpLtRRR: begin
        wb.destEn   = 1'b1;
        wb.destData = phaethonPkg::wordT'(operand.b < operand.c);
      end
      // Jumps
      phaethonPkg::JmpC:  wb.ipLoad = 1'b1;
      phaethonPkg::JeC:   wb.ipLoad = flags[phaethonPkg::flagEq];
      phaethonPkg::JneC:  wb.ipLoad = !flags[phaethonPkg::flagEq];
      phaethonPkg::JzRC:  wb.ipLoad = (operand.c == '0);
      phaethonPkg::JnzRC: wb.ipLoad = (operand.c != '0);
      // Arithmetic
      phaethonPkg::AddRRC: {wb.destEn, wb.destData} = {1'b1, operand.b + dataWord};
      phaethonPkg::AddRRR: {wb.destEn, wb.destData} = {1'b1, operand.b + operand.c};
      phaethonPkg::SubRRC: {wb.destEn, wb.destData} = {1'b1, operand.b - dataWord};
      phaethonPkg::SubRRR: {wb.destEn, wb.destData} = {1'b1, operand.b - operand.c};
      phaethonPkg::IncR:   {wb.destEn, wb.destData} = {1'b1, operand.a + 32'd1};
      phaethonPkg::DecR:   {wb.destEn, wb.destData} = {1'b1, operand.a - 32'd1};
      phaethonPkg::ShlRRR: {wb.destEn, wb.destData} = {1'b1, operand.b << operand.c};
      phaethonPkg::ShrRRR: {wb.destEn, wb.destData} = {1'b1, operand.b >> operand.c};
      phaethonPkg::NegRR:  {wb.destEn, wb.destData} = {1'b1, -operand.b};
      phaethonPkg::Stall: begin
        wb.ipLoad   = 1'b1;
        wb.ipTarget = ip;  // Spin on own address
      end
      default: begin
      end
    endcase
  end

  // Debug port, one pulse per DoutR
  assign isDout = commit && (instr.op == phaethonPkg::DoutR);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      debugOut   <= '0;
      debugValid <= 1'b0;
    end else begin
      debugValid <= isDout;
      if (isDout) debugOut <= operand.a;
    end
  end

endmodule

//--- memAccess.sv
`timescale 1ns/100ps

module memAccess (
  input  phaethonPkg::instrT   instr,
  input  phaethonPkg::operandT operand,
  input  phaethonPkg::wordT    dataWord,
  input  phaethonPkg::wordT    sp,
  input  phaethonPkg::wordT    ip,
  output phaethonPkg::memReqT  memReq
);

  always_comb begin
    memReq = '0;
    case (instr.op)
      // Loads
      phaethonPkg::MovRdC: begin
        memReq.read = 1'b1;
        memReq.addr = dataWord;  // Absolute address
      end
      phaethonPkg::MovRdRo: begin
        memReq.read = 1'b1;
        memReq.addr = dataWord + operand.b;  // Base b plus offset
      end
      phaethonPkg::MovRdR: begin
        memReq.read = 1'b1;
        memReq.addr = operand.b;
      end
      // Stores
      phaethonPkg::MovdCR: begin
        memReq.write = 1'b1;
        memReq.addr  = dataWord;
        memReq.data  = operand.b;
      end
      phaethonPkg::MovdRoR: begin
        memReq.write = 1'b1;
        memReq.addr  = dataWord + operand.a;
        memReq.data  = operand.b;
      end
      // Stack grows upward, sp points at the free slot
      phaethonPkg::PushR: begin
        memReq.write = 1'b1;
        memReq.addr  = sp;
        memReq.data  = operand.a;
      end
      phaethonPkg::CallR: begin
        memReq.write = 1'b1;
        memReq.addr  = sp;
        memReq.data  = ip;  // Own address, Ret adds 4
      end
      phaethonPkg::PopR, phaethonPkg::Ret: begin
        memReq.read = 1'b1;
        memReq.addr = sp - phaethonPkg::wordBytes;  // Top of stack
      end
      default: begin
      end
    endcase
  end

endmodule

//--- regFile.sv
`timescale 1ns/100ps

module regFile (
  input  logic                   clk,
  input  logic                   reset,
  input  phaethonPkg::instrT     instr,
  input  logic                   operandLoad,
  input  logic                   commit,
  input  phaethonPkg::writebackT wb,
  output phaethonPkg::operandT   operand,
  output phaethonPkg::wordT      sp,
  output phaethonPkg::flagsT     flags
);

  phaethonPkg::wordT regs [phaethonPkg::numRegs];

  // Writeback, later writes override earlier ones
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < phaethonPkg::numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (commit) begin
      if (wb.destEn) regs[wb.destReg] <= wb.destData;
      if (wb.spEn) regs[phaethonPkg::stackReg] <= wb.spData;  // Pop into r0 still moves sp
      if (wb.flagsEn) regs[phaethonPkg::flagReg][2:0] <= wb.flags;  // Upper bits kept
    end
  end

  // Operand reads, captured once per instruction
  always_ff @(posedge clk) begin
    if (operandLoad) begin
      operand.a <= regs[instr.ra];
      operand.b <= regs[instr.rb];
      operand.c <= regs[instr.rc];
    end
  end

  // Live stack pointer and flags
  assign sp    = regs[phaethonPkg::stackReg];
  assign flags = regs[phaethonPkg::flagReg][2:0];

endmodule

//--- instrDecode.sv
`timescale 1ns/100ps

module instrDecode (
  input  logic               clk,
  input  logic               reset,
  input  phaethonPkg::wordT  ramIn,
  input  logic               decodeLoad,
  output phaethonPkg::instrT instr,
  output logic               is8,       // Constant word follows
  output logic               isRam,     // Data access needed
  output logic               readsRam   // Data access is a read
);

  // Instruction register
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      instr <= '0;
    end else if (decodeLoad) begin
      instr.op <= phaethonPkg::opcodeT'(ramIn[7:0]);
      // Low 6 bits of each register byte
      instr.ra <= ramIn[13:8];
      instr.rb <= ramIn[21:16];
      instr.rc <= ramIn[29:24];
    end
  end

  // Classification of the latched opcode
  assign is8      = phaethonPkg::is8Byte(instr.op);
  assign isRam    = phaethonPkg::isRamOp(instr.op);
  assign readsRam = phaethonPkg::readsRam(instr.op);

endmodule

//--- cpuSequencer.sv
`timescale 1ns/100ps

module cpuSequencer (
  input  logic                   clk,
  input  logic                   reset,
  input  phaethonPkg::wordT      ramIn,
  input  logic                   is8,
  input  logic                   isRam,
  input  logic                   readsRam,
  input  phaethonPkg::memReqT    memReq,
  input  phaethonPkg::writebackT wb,
  output logic                   decodeLoad,   // Latch instruction word
  output logic                   operandLoad,  // Latch register reads
  output logic                   commit,       // Apply writeback
  output phaethonPkg::wordT      ip,
  output phaethonPkg::wordT      dataWord,
  output phaethonPkg::wordT      ramValue,
  output phaethonPkg::wordT      ramAddress,
  output phaethonPkg::wordT      ramOut,
  output logic                   readReq,
  output logic                   writeReq
);

  phaethonPkg::modeT mode;
  phaethonPkg::wordT ipStep;  // Instruction length

  assign decodeLoad  = (mode == phaethonPkg::Decode);
  assign operandLoad = (mode == phaethonPkg::ReadRegs);
  assign commit      = (mode == phaethonPkg::Execute);

  assign ipStep = is8 ? 2 * phaethonPkg::wordBytes : phaethonPkg::wordBytes;

  // Mode sequencing, ip and request strobes
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mode     <= phaethonPkg::Fetch;
      ip       <= '0;
      readReq  <= 1'b0;
      writeReq <= 1'b0;
      dataWord <= phaethonPkg::resetDataWord;
    end else begin
      // Strobes last one cycle
      readReq  <= 1'b0;
      writeReq <= 1'b0;
      case (mode)
        phaethonPkg::Fetch: begin
          readReq <= 1'b1;  // Instruction word at ip
          mode    <= phaethonPkg::FetchWait;
        end
        phaethonPkg::FetchWait: mode <= phaethonPkg::Decode;
        phaethonPkg::Decode:    mode <= phaethonPkg::ReadRegs;  // Word sampled here
        phaethonPkg::ReadRegs: begin
          if (is8) begin
            readReq <= 1'b1;  // Constant word at ip + 4
            mode    <= phaethonPkg::DataWait;
          end else if (isRam) begin
            mode <= phaethonPkg::MemRequest;
          end else begin
            mode <= phaethonPkg::Execute;
          end
        end
        phaethonPkg::DataWait: mode <= phaethonPkg::DataDone;
        phaethonPkg::DataDone: begin
          dataWord <= ramIn;
          mode     <= isRam ? phaethonPkg::MemRequest : phaethonPkg::Execute;
        end
        phaethonPkg::MemRequest: begin
          readReq  <= memReq.read;
          writeReq <= memReq.write;  // Store lands at end of MemWait
          mode     <= phaethonPkg::MemWait;
        end
        phaethonPkg::MemWait: mode <= phaethonPkg::MemDone;
        phaethonPkg::MemDone: mode <= phaethonPkg::Execute;
        phaethonPkg::Execute: begin
          // Jump, call, return and stall load ip
          ip   <= wb.ipLoad ? wb.ipTarget : ip + ipStep;
          mode <= phaethonPkg::Fetch;
        end
        default: mode <= phaethonPkg::Fetch;
      endcase
    end
  end

  // Memory address, store data and read value
  always_ff @(posedge clk) begin
    case (mode)
      phaethonPkg::Fetch:    ramAddress <= ip;
      phaethonPkg::ReadRegs: ramAddress <= ip + phaethonPkg::wordBytes;
      phaethonPkg::MemRequest: begin
        ramAddress <= memReq.addr;
        ramOut     <= memReq.data;
      end
      phaethonPkg::MemDone: begin
        if (readsRam) ramValue <= ramIn;  // Second edge after request
      end
      default: begin
      end
    endcase
  end

endmodule

//--- phaethonPkg.sv
package phaethonPkg;

  // Meaningful widths
  typedef logic [31:0] wordT;     // Data word, address or raw instruction
  typedef logic [5:0]  regAddrT;  // Index into the 64-entry register file
  typedef logic [2:0]  flagsT;    // Compare flags kept in r1

  localparam int      numRegs       = 64;
  localparam regAddrT stackReg      = 6'd0;  // Stack pointer register
  localparam regAddrT flagReg       = 6'd1;  // Flags register
  localparam wordT    wordBytes     = 32'd4;
  localparam wordT    resetDataWord = 32'hffffffff;

  // Bit positions inside flagsT
  localparam int flagEq = 0;
  localparam int flagLt = 1;
  localparam int flagGt = 2;

  // Opcode byte, zero and unlisted values fall through as no-ops
  typedef enum logic [7:0] {
    MovRC = 8'd1, MovRR, MovRdC, MovRdRo, MovRdR, MovdCR, MovdRoR,
    PushR, PopR, CallR, Ret,
    CmpRR, CmpRC, CmpERRR, CmpLtRRR,
    JmpC, JeC, JneC, JzRC, JnzRC,
    AddRRC, AddRRR, SubRRC, SubRRR, IncR, DecR, ShlRRR, ShrRRR, NegRR,
    DoutR, Stall
  } opcodeT;

  // Sequencer states
  typedef enum logic [3:0] {
    Fetch, FetchWait, Decode, ReadRegs, DataWait, DataDone,
    MemRequest, MemWait, MemDone, Execute
  } modeT;

  // Decoded instruction word
  typedef struct packed {
    opcodeT  op;
    regAddrT ra;  // Byte 1
    regAddrT rb;  // Byte 2
    regAddrT rc;  // Byte 3
  } instrT;

  typedef struct packed {
    wordT a;
    wordT b;
    wordT c;
  } operandT;

  // Everything committed in Execute
  typedef struct packed {
    logic    destEn;
    regAddrT destReg;
    wordT    destData;
    logic    spEn;
    wordT    spData;
    logic    flagsEn;
    flagsT   flags;
    logic    ipLoad;
    wordT    ipTarget;
  } writebackT;

  typedef struct packed {
    logic read;
    logic write;
    wordT addr;
    wordT data;
  } memReqT;

  // Opcodes followed by a constant word, so 8 bytes long
  function automatic logic is8Byte(opcodeT op);
    case (op)
      MovRC, MovRdC, MovRdRo, MovdCR, MovdRoR, CmpRC,
      JmpC, JeC, JneC, JzRC, JnzRC, AddRRC, SubRRC: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Needs a data access after decode
  function automatic logic isRamOp(opcodeT op);
    case (op)
      MovRdC, MovRdRo, MovRdR, MovdCR, MovdRoR,
      PushR, PopR, CallR, Ret: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic readsRam(opcodeT op);
    case (op)
      MovRdC, MovRdRo, MovRdR, PopR, Ret: return 1'b1;  // Loads and stack reads
      default: return 1'b0;
    endcase
  endfunction

endpackage
